//--- files.f
source/enemy_pkg.sv
source/phase_control.sv
source/pattern_decode.sv
source/arrow_execute.sv
source/pixel_result.sv
source/enemy_phase.sv
testbench/phase_checker.sv
testbench/tb_enemy_phase.sv

//--- source/arrow_execute.sv
`default_nettype none
`timescale 1ns/1ps

module arrow_execute #(
	parameter int STEP_CYCLES = 4,
	parameter int TRAVEL_STEPS = 8,
	parameter int N_LANES = 4
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          busy,
	input  logic                                          spawn,
	input  logic [$clog2(N_LANES)-1:0]                    spawn_lane,
	input  enemy_pkg::dir_t                               spawn_dir,
	input  enemy_pkg::dir_t                               rotate,
	output logic [N_LANES-1:0]                            lane_free,
	output logic [N_LANES-1:0]                            lane_alive,
	output enemy_pkg::dir_t [N_LANES-1:0]                 lane_dir,
	output logic [N_LANES-1:0][$clog2(TRAVEL_STEPS+1)-1:0] lane_step,
	output logic                                          any_alive,
	output logic                                          hit_pulse
);

	localparam int LANE_W = $clog2(N_LANES);
	localparam int STEP_W = $clog2(TRAVEL_STEPS + 1);
	localparam int DIV_W = $clog2(STEP_CYCLES + 1);

	logic [DIV_W-1:0] div;
	logic step_tick;
	logic [N_LANES-1:0] arrive;
	logic [N_LANES-1:0] lane_hit;

	// one divider paces every lane
	assign step_tick = (div == DIV_W'(STEP_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (rst || !busy) begin
			div <= '0;
		end else if (step_tick) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	// arrival and shield compare
	always_comb begin
		for (int i = 0; i < N_LANES; i++) begin
			arrive[i] = lane_alive[i] && (lane_step[i] == STEP_W'(TRAVEL_STEPS));
			lane_hit[i] = arrive[i] && (rotate != lane_dir[i]);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_LANES; i++) begin
			if (rst) begin
				lane_alive[i] <= 1'b0;
			end else if (spawn && spawn_lane == LANE_W'(i)) begin
				lane_alive[i] <= 1'b1;
				lane_dir[i] <= spawn_dir;
				lane_step[i] <= '0;
			end else if (arrive[i]) begin
				// resolved, blocked or not
				lane_alive[i] <= 1'b0;
			end else if (lane_alive[i] && step_tick) begin
				lane_step[i] <= lane_step[i] + 1'b1;
			end
		end
	end

	assign lane_free = ~lane_alive;
	assign any_alive = |lane_alive;
	assign hit_pulse = |lane_hit;

endmodule

`default_nettype wire

//--- source/enemy_phase.sv
`default_nettype none
`timescale 1ns/1ps

module enemy_phase #(
	parameter int TICK_CYCLES = 1000,
	parameter int STEP_CYCLES = 500,
	parameter int TRAVEL_STEPS = 8,
	parameter int N_LANES = 4
) (
	input  logic                          clk,
	input  logic                          rst,
	input  enemy_pkg::game_state_t        state_in,
	input  logic [enemy_pkg::HCOUNT_W-1:0] hcount,
	input  logic [enemy_pkg::VCOUNT_W-1:0] vcount,
	input  enemy_pkg::dir_t               rotate,
	output logic                          busy,
	output logic                          finished,
	output logic                          damage,
	output logic [enemy_pkg::PIXEL_W-1:0]  pixel
);

	localparam int LANE_W = $clog2(N_LANES);
	localparam int STEP_W = $clog2(TRAVEL_STEPS + 1);

	logic pattern_done;
	logic any_alive;
	logic hit_pulse;
	logic spawn;
	logic [LANE_W-1:0] spawn_lane;
	enemy_pkg::dir_t spawn_dir;
	logic [N_LANES-1:0] lane_free;
	logic [N_LANES-1:0] lane_alive;
	enemy_pkg::dir_t [N_LANES-1:0] lane_dir;
	logic [N_LANES-1:0][STEP_W-1:0] lane_step;

	phase_control u_phase_control (
		.clk          (clk),
		.rst          (rst),
		.state_in     (state_in),
		.pattern_done (pattern_done),
		.any_alive    (any_alive),
		.hit_pulse    (hit_pulse),
		.busy         (busy),
		.finished     (finished),
		.damage       (damage)
	);

	pattern_decode #(
		.TICK_CYCLES (TICK_CYCLES),
		.N_LANES     (N_LANES)
	) u_pattern_decode (
		.clk          (clk),
		.rst          (rst),
		.busy         (busy),
		.lane_free    (lane_free),
		.spawn        (spawn),
		.spawn_lane   (spawn_lane),
		.spawn_dir    (spawn_dir),
		.pattern_done (pattern_done)
	);

	arrow_execute #(
		.STEP_CYCLES  (STEP_CYCLES),
		.TRAVEL_STEPS (TRAVEL_STEPS),
		.N_LANES      (N_LANES)
	) u_arrow_execute (
		.clk        (clk),
		.rst        (rst),
		.busy       (busy),
		.spawn      (spawn),
		.spawn_lane (spawn_lane),
		.spawn_dir  (spawn_dir),
		.rotate     (rotate),
		.lane_free  (lane_free),
		.lane_alive (lane_alive),
		.lane_dir   (lane_dir),
		.lane_step  (lane_step),
		.any_alive  (any_alive),
		.hit_pulse  (hit_pulse)
	);

	pixel_result #(
		.TRAVEL_STEPS (TRAVEL_STEPS),
		.N_LANES      (N_LANES)
	) u_pixel_result (
		.busy       (busy),
		.rotate     (rotate),
		.hcount     (hcount),
		.vcount     (vcount),
		.lane_alive (lane_alive),
		.lane_dir   (lane_dir),
		.lane_step  (lane_step),
		.pixel      (pixel)
	);

endmodule

`default_nettype wire

//--- source/enemy_pkg.sv
`default_nettype none

package enemy_pkg;

	// game state bus, only the attack code matters to this block
	typedef enum logic [3:0] {
		ST_IDLE         = 4'b0000,
		ST_MENU         = 4'b0001,
		ST_PLAYER_TURN  = 4'b0010,
		ST_ENEMY_ATTACK = 4'b1000
	} game_state_t;

	// arrow origin side and shield facing share one encoding
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_RIGHT = 2'd1,
		DIR_DOWN  = 2'd2,
		DIR_LEFT  = 2'd3
	} dir_t;

	localparam int PATTERN_LEN = 8;

	// wait before each spawn, in ticks; zero ends the pattern
	localparam logic [2:0] PATTERN_TIME [0:PATTERN_LEN-1] = '{
		3'd2, 3'd1, 3'd3, 3'd1, 3'd2, 3'd1, 3'd0, 3'd0
	};

	localparam dir_t PATTERN_DIR [0:PATTERN_LEN-1] = '{
		DIR_UP, DIR_RIGHT, DIR_DOWN, DIR_LEFT,
		DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT
	};

	// scan position and pixel format
	localparam int HCOUNT_W = 11;
	localparam int VCOUNT_W = 10;
	localparam int PIXEL_W = 12;

	localparam int CENTER_X = 512;
	localparam int CENTER_Y = 384;

	// fixed frame box around the player
	localparam int FRAME_X = 432;
	localparam int FRAME_Y = 304;
	localparam int FRAME_SIZE = 160;
	localparam int FRAME_THICK = 8;

	localparam logic [PIXEL_W-1:0] FRAME_COLOR = 12'hFFF;
	localparam logic [PIXEL_W-1:0] SHIELD_COLOR = 12'h0F0;
	localparam logic [PIXEL_W-1:0] ARROW_COLOR = 12'hF00;

	// square sprites, offset measured from centre to sprite centre
	localparam int ARROW_SIZE = 16;
	localparam int SHIELD_OFFSET = 24;

endpackage

`default_nettype wire

//--- source/pattern_decode.sv
`default_nettype none
`timescale 1ns/1ps

module pattern_decode #(
	parameter int TICK_CYCLES = 8,
	parameter int N_LANES = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         busy,
	input  logic [N_LANES-1:0]           lane_free,
	output logic                         spawn,
	output logic [$clog2(N_LANES)-1:0]   spawn_lane,
	output enemy_pkg::dir_t              spawn_dir,
	output logic                         pattern_done
);

	localparam int SLOT_W = $clog2(enemy_pkg::PATTERN_LEN);
	localparam int LANE_W = $clog2(N_LANES);
	// longest wait is 7 ticks
	localparam int TIMER_W = $clog2(7 * TICK_CYCLES + 1);

	logic [SLOT_W-1:0] slot;
	logic [TIMER_W-1:0] timer;
	logic [TIMER_W-1:0] limit;
	logic [2:0] wait_ticks;
	logic at_zero;
	logic done;

	// slot decode
	assign wait_ticks = enemy_pkg::PATTERN_TIME[slot];
	assign spawn_dir = enemy_pkg::PATTERN_DIR[slot];
	assign at_zero = (wait_ticks == 3'd0);
	assign limit = TIMER_W'(wait_ticks) * TIMER_W'(TICK_CYCLES);

	// lanes are reused round robin
	assign spawn_lane = LANE_W'(slot % N_LANES);

	// waits at the limit until the target lane has landed
	assign spawn = busy && !done && !at_zero && (timer == limit) && lane_free[spawn_lane];

	assign pattern_done = done;

	always_ff @(posedge clk) begin
		if (rst || !busy) begin
			slot <= '0;
			timer <= '0;
			done <= 1'b0;
		end else if (!done) begin
			if (at_zero) begin
				done <= 1'b1;
			end else if (spawn) begin
				// the spawn cycle itself counts toward the next wait
				timer <= TIMER_W'(1);
				if (slot == SLOT_W'(enemy_pkg::PATTERN_LEN - 1)) begin
					done <= 1'b1;
				end else begin
					slot <= slot + 1'b1;
				end
			end else if (timer != limit) begin
				timer <= timer + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/phase_control.sv
`default_nettype none
`timescale 1ns/1ps

module phase_control (
	input  logic                   clk,
	input  logic                   rst,
	input  enemy_pkg::game_state_t state_in,
	input  logic                   pattern_done,
	input  logic                   any_alive,
	input  logic                   hit_pulse,
	output logic                   busy,
	output logic                   finished,
	output logic                   damage
);

	enemy_pkg::game_state_t prev_state;
	logic start;
	logic phase_end;

	// entry into the attack state, not the level
	assign start = (state_in == enemy_pkg::ST_ENEMY_ATTACK) && (state_in != prev_state);

	// pattern exhausted and nothing left in flight
	assign phase_end = pattern_done && !any_alive;

	always_ff @(posedge clk) begin
		if (rst) begin
			prev_state <= enemy_pkg::ST_IDLE;
			busy <= 1'b0;
			finished <= 1'b0;
			damage <= 1'b0;
		end else begin
			prev_state <= state_in;
			finished <= 1'b0;
			// one cycle behind the lane resolve
			damage <= hit_pulse;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
				end
			end else if (phase_end) begin
				// busy drops on the same edge that raises finished
				busy <= 1'b0;
				finished <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pixel_result.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_result #(
	parameter int TRAVEL_STEPS = 8,
	parameter int N_LANES = 4
) (
	input  logic                                           busy,
	input  enemy_pkg::dir_t                                rotate,
	input  logic [enemy_pkg::HCOUNT_W-1:0]                 hcount,
	input  logic [enemy_pkg::VCOUNT_W-1:0]                 vcount,
	input  logic [N_LANES-1:0]                             lane_alive,
	input  enemy_pkg::dir_t [N_LANES-1:0]                  lane_dir,
	input  logic [N_LANES-1:0][$clog2(TRAVEL_STEPS+1)-1:0] lane_step,
	output logic [enemy_pkg::PIXEL_W-1:0]                  pixel
);

	localparam int FX = enemy_pkg::FRAME_X;
	localparam int FY = enemy_pkg::FRAME_Y;
	localparam int FS = enemy_pkg::FRAME_SIZE;
	localparam int FT = enemy_pkg::FRAME_THICK;
	localparam int HALF = enemy_pkg::ARROW_SIZE / 2;
	// pixels an arrow moves per step, from frame edge down to the shield
	localparam int STEP_PX = (FS / 2 - enemy_pkg::SHIELD_OFFSET) / TRAVEL_STEPS;

	int h;
	int v;
	logic bottom_hit;
	logic frame_hit;
	logic shield_hit;
	logic arrow_hit;

	function automatic logic in_box(input int px, input int py, input int x0, input int y0,
		input int w, input int ht);
		return (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + ht);
	endfunction

	// square centred distance pixels from the centre on the given side
	function automatic logic on_square(input enemy_pkg::dir_t dir, input int distance,
		input int px, input int py);
		int cx;
		int cy;
		cx = enemy_pkg::CENTER_X;
		cy = enemy_pkg::CENTER_Y;
		case (dir)
			enemy_pkg::DIR_UP:    cy = cy - distance;
			enemy_pkg::DIR_RIGHT: cx = cx + distance;
			enemy_pkg::DIR_DOWN:  cy = cy + distance;
			default:              cx = cx - distance;
		endcase
		return in_box(px, py, cx - HALF, cy - HALF, enemy_pkg::ARROW_SIZE,
			enemy_pkg::ARROW_SIZE);
	endfunction

	assign h = int'(hcount);
	assign v = int'(vcount);

	// four bars of the box
	assign bottom_hit = in_box(h, v, FX, FY + FS - FT, FS, FT);
	assign frame_hit = bottom_hit
		|| in_box(h, v, FX, FY, FS, FT)
		|| in_box(h, v, FX, FY, FT, FS)
		|| in_box(h, v, FX + FS - FT, FY, FT, FS);

	assign shield_hit = on_square(rotate, enemy_pkg::SHIELD_OFFSET, h, v);

	always_comb begin
		arrow_hit = 1'b0;
		for (int i = 0; i < N_LANES; i++) begin
			if (lane_alive[i] && on_square(lane_dir[i],
				enemy_pkg::SHIELD_OFFSET + (TRAVEL_STEPS - int'(lane_step[i])) * STEP_PX,
				h, v)) begin
				arrow_hit = 1'b1;
			end
		end
	end

	// frame over shield over arrows
	always_comb begin
		if (!busy) begin
			pixel = bottom_hit ? enemy_pkg::FRAME_COLOR : '0;
		end else if (frame_hit) begin
			pixel = enemy_pkg::FRAME_COLOR;
		end else if (shield_hit) begin
			pixel = enemy_pkg::SHIELD_COLOR;
		end else if (arrow_hit) begin
			pixel = enemy_pkg::ARROW_COLOR;
		end else begin
			pixel = '0;
		end
	end

endmodule

`default_nettype wire

//--- testbench/phase_checker.sv
`default_nettype none
`timescale 1ns/1ps

module phase_checker #(
	parameter int TICK_CYCLES = 4,
	parameter int STEP_CYCLES = 2,
	parameter int TRAVEL_STEPS = 6
) (
	input  logic                          clk,
	input  logic                          rst,
	input  enemy_pkg::game_state_t        state_in,
	input  logic                          busy,
	input  logic                          finished,
	input  logic                          damage,
	input  logic [enemy_pkg::PIXEL_W-1:0] pixel,
	input  logic                          check_pixel,
	input  logic [enemy_pkg::PIXEL_W-1:0] exp_pixel,
	input  int                            exp_damage,
	output int                            errors
);

	enemy_pkg::game_state_t prev_state;
	logic busy_q;
	logic finished_q;
	logic start_q;
	logic rst_seen;
	int damage_count;
	int phase_cycles;
	int min_cycles;

	// total wait of the pattern in ticks, up to the first zero slot
	function automatic int pattern_ticks();
		int sum;
		logic ended;
		sum = 0;
		ended = 1'b0;
		for (int i = 0; i < enemy_pkg::PATTERN_LEN; i++) begin
			if (enemy_pkg::PATTERN_TIME[i] == 3'd0) begin
				ended = 1'b1;
			end
			if (!ended) begin
				sum = sum + int'(enemy_pkg::PATTERN_TIME[i]);
			end
		end
		return sum;
	endfunction

	task automatic value_error(input string name, input int expected, input int got);
		$display("Error at %0t: %s expected %0h got %0h", $time, name, expected, got);
		errors++;
	endtask

	task automatic plain_error(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	initial begin
		errors = 0;
		prev_state = enemy_pkg::ST_IDLE;
		busy_q = 1'b0;
		finished_q = 1'b0;
		start_q = 1'b0;
		rst_seen = 1'b0;
		damage_count = 0;
		phase_cycles = 0;
		// last spawn plus the shortest possible flight
		min_cycles = pattern_ticks() * TICK_CYCLES + (TRAVEL_STEPS - 1) * STEP_CYCLES;
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst) begin
			rst_seen = 1'b1;
			prev_state = enemy_pkg::ST_IDLE;
			busy_q = 1'b0;
			finished_q = 1'b0;
			start_q = 1'b0;
		end else begin
			if (rst_seen) begin
				if (busy !== 1'b0) value_error("busy", 0, busy);
				if (finished !== 1'b0) value_error("finished", 0, finished);
				if (damage !== 1'b0) value_error("damage", 0, damage);
				rst_seen = 1'b0;
			end

			// busy rises one cycle after a start edge and at no other time
			if ((busy && !busy_q) != start_q) begin
				value_error("busy", start_q, busy);
			end

			if (busy && !busy_q) begin
				damage_count = 0;
				phase_cycles = 0;
			end else if (busy) begin
				phase_cycles++;
			end
			if (damage === 1'b1) begin
				damage_count++;
			end

			if (finished === 1'b1) begin
				if (busy !== 1'b0) value_error("busy", 0, busy);
				if (!busy_q) plain_error("finished came without a busy phase before it");
				if (finished_q) plain_error("finished stayed high for more than one cycle");
				if (damage_count != exp_damage) begin
					value_error("damage count", exp_damage, damage_count);
				end
				if (phase_cycles < min_cycles) begin
					plain_error("finished came before the last arrow could have landed");
				end
			end

			if (check_pixel && (pixel !== exp_pixel)) begin
				value_error("pixel", exp_pixel, pixel);
			end

			start_q = (state_in == enemy_pkg::ST_ENEMY_ATTACK) && (state_in != prev_state)
				&& !busy;
			prev_state = state_in;
			busy_q = busy;
			finished_q = finished;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_enemy_phase.sv
`default_nettype none
`timescale 1ns/1ps

module tb_enemy_phase;

	localparam int TICK_CYCLES = 4;
	localparam int STEP_CYCLES = 2;
	localparam int TRAVEL_STEPS = 6;
	localparam int N_LANES = 4;
	localparam int N_ROWS = 8;
	localparam int ROW_W = 48;
	// idle and pixel check cycles around each phase
	localparam int ROW_SLACK = 16;

	// random flag, rotate, scan x, scan y, pixel while idle, pixel while busy
	localparam logic [ROW_W-1:0] TABLE [0:N_ROWS-1] = '{
		{1'b0, enemy_pkg::DIR_UP, 11'd512, 10'd306, 12'h000, enemy_pkg::FRAME_COLOR},
		{1'b0, enemy_pkg::DIR_UP, 11'd512, 10'd360, 12'h000, enemy_pkg::SHIELD_COLOR},
		{1'b0, enemy_pkg::DIR_RIGHT, 11'd536, 10'd384, 12'h000, enemy_pkg::SHIELD_COLOR},
		{1'b0, enemy_pkg::DIR_DOWN, 11'd512, 10'd408, 12'h000, enemy_pkg::SHIELD_COLOR},
		{1'b0, enemy_pkg::DIR_LEFT, 11'd488, 10'd384, 12'h000, enemy_pkg::SHIELD_COLOR},
		{1'b1, enemy_pkg::DIR_UP, 11'd450, 10'd320, 12'h000, 12'h000},
		{1'b0, enemy_pkg::DIR_DOWN, 11'd512, 10'd460, enemy_pkg::FRAME_COLOR,
			enemy_pkg::FRAME_COLOR},
		{1'b1, enemy_pkg::DIR_UP, 11'd580, 10'd440, 12'h000, 12'h000}
	};

	logic clk;
	logic rst;
	enemy_pkg::game_state_t state_in;
	logic [enemy_pkg::HCOUNT_W-1:0] hcount;
	logic [enemy_pkg::VCOUNT_W-1:0] vcount;
	enemy_pkg::dir_t rotate;
	logic busy;
	logic finished;
	logic damage;
	logic [enemy_pkg::PIXEL_W-1:0] pixel;
	logic check_pixel;
	logic [enemy_pkg::PIXEL_W-1:0] exp_pixel;
	int exp_damage;
	int errors;
	int cycles;
	int timeout_limit;
	logic [31:0] lcg_state;
	int passed;
	int failed;

	enemy_phase #(
		.TICK_CYCLES  (TICK_CYCLES),
		.STEP_CYCLES  (STEP_CYCLES),
		.TRAVEL_STEPS (TRAVEL_STEPS),
		.N_LANES      (N_LANES)
	) dut (
		.clk      (clk),
		.rst      (rst),
		.state_in (state_in),
		.hcount   (hcount),
		.vcount   (vcount),
		.rotate   (rotate),
		.busy     (busy),
		.finished (finished),
		.damage   (damage),
		.pixel    (pixel)
	);

	phase_checker #(
		.TICK_CYCLES  (TICK_CYCLES),
		.STEP_CYCLES  (STEP_CYCLES),
		.TRAVEL_STEPS (TRAVEL_STEPS)
	) u_checker (
		.clk         (clk),
		.rst         (rst),
		.state_in    (state_in),
		.busy        (busy),
		.finished    (finished),
		.damage      (damage),
		.pixel       (pixel),
		.check_pixel (check_pixel),
		.exp_pixel   (exp_pixel),
		.exp_damage  (exp_damage),
		.errors      (errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// slots before the first zero wait whose side the shield does not face
	function automatic int expected_misses(input enemy_pkg::dir_t rot);
		int n;
		logic ended;
		n = 0;
		ended = 1'b0;
		for (int i = 0; i < enemy_pkg::PATTERN_LEN; i++) begin
			if (enemy_pkg::PATTERN_TIME[i] == 3'd0) begin
				ended = 1'b1;
			end
			if (!ended && (enemy_pkg::PATTERN_DIR[i] != rot)) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic int total_ticks();
		int sum;
		logic ended;
		sum = 0;
		ended = 1'b0;
		for (int i = 0; i < enemy_pkg::PATTERN_LEN; i++) begin
			if (enemy_pkg::PATTERN_TIME[i] == 3'd0) begin
				ended = 1'b1;
			end
			if (!ended) begin
				sum = sum + int'(enemy_pkg::PATTERN_TIME[i]);
			end
		end
		return sum;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic request_pixel_check(input logic [enemy_pkg::PIXEL_W-1:0] expected);
		exp_pixel = expected;
		check_pixel = 1'b1;
		next_cycle();
		check_pixel = 1'b0;
	endtask

	task automatic wait_for_busy();
		while (!busy) begin
			next_cycle();
		end
	endtask

	task automatic wait_for_finished();
		while (!finished) begin
			next_cycle();
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > timeout_limit) begin
			$display("timeout: the run did not end within %0d cycles", timeout_limit);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin : run_tests
		logic [ROW_W-1:0] row;
		int errors_before;
		cycles = 0;
		timeout_limit = N_ROWS * (2 * (total_ticks() * TICK_CYCLES
			+ TRAVEL_STEPS * STEP_CYCLES) + ROW_SLACK) + 10;
		rst = 1'b1;
		state_in = enemy_pkg::ST_IDLE;
		hcount = '0;
		vcount = '0;
		rotate = enemy_pkg::DIR_UP;
		check_pixel = 1'b0;
		exp_pixel = '0;
		exp_damage = 0;
		lcg_state = 32'hdaac6597;
		passed = 0;
		failed = 0;

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		next_cycle();

		for (int r = 0; r < N_ROWS; r++) begin
			row = TABLE[r];
			errors_before = errors;
			if (row[47]) begin
				lcg_state = lcg_next(lcg_state);
				rotate = enemy_pkg::dir_t'(lcg_state[31:30]);
			end else begin
				rotate = enemy_pkg::dir_t'(row[46:45]);
			end
			hcount = row[44:34];
			vcount = row[33:24];
			exp_damage = expected_misses(rotate);
			next_cycle();
			request_pixel_check(row[23:12]);

			state_in = enemy_pkg::ST_ENEMY_ATTACK;
			wait_for_busy();
			// first spawn is still several ticks away
			request_pixel_check(row[11:0]);
			wait_for_finished();

			// attack code held on, no second phase may start
			repeat (3) next_cycle();
			state_in = enemy_pkg::ST_IDLE;
			next_cycle();

			if (errors == errors_before) begin
				passed++;
				$display("test %0d: rotate %0d, %0d misses, ok", r, rotate, exp_damage);
			end else begin
				failed++;
				$display("test %0d: rotate %0d, %0d misses, FAILED", r, rotate, exp_damage);
			end
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			N_ROWS, passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
